/* sim/mac_vectors.txt */
# columns: test name, 48-bit mac in hex, nack code
# nack code 0 clean read, 1 nack device address, 2 nack word address
clean_basic fcc23d0a1b2c 0
clean_ones ffffffffffff 0
clean_zeros 000000000000 0
nack_dev_addr 0123456789ab 1
clean_after_nack a5c35a3c0f96 0
nack_word_addr 8e2b47d19f60 2
clean_last 02a0c9e1770d 0

/* flist.f */
+incdir+verilog
verilog/i2c_pkg.sv
verilog/i2c_bit_engine.sv
verilog/boot_timer.sv
verilog/eeprom_read_sequencer.sv
verilog/mac_reader_fsm.sv
verilog/mac_reader_top.sv
sim/eeprom_model.sv
sim/tb_mac_reader.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_mac_reader -f flist.f -o sim_mac_reader \
	&& ./obj_dir/sim_mac_reader | tee /dev/stderr | grep -q "Test passed" \
	&& echo "simulation ok" \
	|| { echo "simulation not ok"; exit 1; }

/* sim/tb_mac_reader.sv */
`timescale 1ns/1ps
`include "mac_reader_defines.svh"

module tb_mac_reader;

	localparam int MAX_VEC     = 16;
	localparam int DONE_WAIT   = 8000;   // per vector
	localparam int HOLD_CYCLES = 500;

	logic               clk;
	logic               rst_n;
	logic               dut_scl_oe;
	logic               dut_sda_oe;
	logic               eep_sda_oe;
	logic               ready;
	logic               done;
	logic               fail;
	i2c_pkg::mac_addr_t mac;
	wire                scl;
	wire                sda;

	i2c_pkg::mac_addr_t model_mac;
	int                 model_code;
	i2c_pkg::i2c_byte_t dev_w_seen;
	i2c_pkg::i2c_byte_t word_seen;
	i2c_pkg::i2c_byte_t dev_r_seen;
	int                 rd_cnt;
	int                 nack_at;
	int                 start_cnt;
	logic               stop_seen;

	logic [127:0]       vec_name [MAX_VEC];
	i2c_pkg::mac_addr_t vec_mac [MAX_VEC];
	int                 vec_code [MAX_VEC];
	int                 nvec;
	logic [127:0]       cur_name;
	int                 errors;
	int                 checks;
	int                 cycles;
	int                 cycle_limit;
	int                 rel_cyc;     // cycles since reset release
	int                 first_scl;   // first cycle with scl pulled
	int                 done_cnt;

	assign scl = !dut_scl_oe;                            // wired-and bus
	assign sda = !(dut_sda_oe || eep_sda_oe);

	mac_reader_top #(.ADDR_PINS(3'd0)) dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.sda_in (sda),
		.scl_oe (dut_scl_oe),
		.sda_oe (dut_sda_oe),
		.ready  (ready),
		.done   (done),
		.fail   (fail),
		.mac    (mac)
	);

	eeprom_model #(.ADDR_PINS(3'd0)) u_eeprom (
		.rst_n      (rst_n),
		.scl        (scl),
		.sda        (sda),
		.mac_data   (model_mac),
		.nack_code  (model_code),
		.sda_oe     (eep_sda_oe),
		.dev_w_seen (dev_w_seen),
		.word_seen  (word_seen),
		.dev_r_seen (dev_r_seen),
		.rd_cnt     (rd_cnt),
		.nack_at    (nack_at),
		.start_cnt  (start_cnt),
		.stop_seen  (stop_seen)
	);

	always #50 clk = !clk;                               // 100 ns period

	//////////////////////////////
	// monitors
	//////////////////////////////

	always @(posedge clk) begin
		if (!rst_n) begin
			rel_cyc   <= 0;
			first_scl <= 0;
			done_cnt  <= 0;
		end else begin
			rel_cyc <= rel_cyc + 1;
			if (dut_scl_oe && first_scl == 0)
				first_scl <= rel_cyc + 1;
			if (done)
				done_cnt <= done_cnt + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("run stopped after %0d cycles without finishing", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	task automatic compare(input string what, input logic [47:0] act, input logic [47:0] exp);
		checks++;
		assert (exp === act) else begin
			errors++;
			$display("FAIL %0s %0s: expected %h actual %h", cur_name, what, exp, act);
		end
	endtask

	task automatic read_vectors();
		int    fd;
		int    rc;
		string line;
		logic [127:0]       n;
		i2c_pkg::mac_addr_t m;
		int    c;
		nvec = 0;
		fd = $fopen("sim/mac_vectors.txt", "r");
		if (fd == 0) begin
			$display("vector file sim/mac_vectors.txt could not be opened");
			return;
		end
		while (!$feof(fd)) begin
			rc = $fgets(line, fd);
			if (rc > 0 && line.len() > 0 && line.getc(0) != "#" && nvec < MAX_VEC) begin
				rc = $sscanf(line, "%s %h %d", n, m, c);
				if (rc == 3) begin
					vec_name[nvec] = n;
					vec_mac[nvec]  = m;
					vec_code[nvec] = c;
					nvec++;
				end
			end
		end
		$fclose(fd);
	endtask

	//////////////////////////////
	// one vector
	//////////////////////////////

	task automatic run_vector(input int idx);
		int                 waited;
		int                 extra;
		int                 drift;
		logic               clean;
		i2c_pkg::mac_addr_t mac_held;
		cur_name   = vec_name[idx];
		clean      = (vec_code[idx] == 0);
		model_mac  = vec_mac[idx];
		model_code = vec_code[idx];
		rst_n      = 1'b0;
		repeat (2) @(negedge clk);
		compare("ready in reset", 48'(ready), 48'd0);
		compare("done in reset", 48'(done), 48'd0);
		compare("fail in reset", 48'(fail), 48'd0);
		compare("mac in reset", mac, 48'd0);
		rst_n  = 1'b1;
		waited = 0;
		while (!done && waited < DONE_WAIT) begin
			@(negedge clk);
			waited++;
		end
		checks++;
		assert (done) else begin
			errors++;
			$display("ERROR %0s: done never arrived within %0d cycles", cur_name, DONE_WAIT);
			return;
		end
		compare("ready", 48'(ready), 48'd1);
		compare("fail", 48'(fail), clean ? 48'd0 : 48'd1);
		compare("mac", mac, clean ? vec_mac[idx] : 48'd0);
		checks++;
		assert (first_scl > `MAC_BOOT_CYCLES) else begin
			errors++;
			$display("ERROR %0s: scl moved %0d cycles after reset, before boot delay",
				cur_name, first_scl);
		end
		mac_held = mac;
		drift    = 0;
		repeat (HOLD_CYCLES) begin
			@(negedge clk);
			if (!ready || mac !== mac_held)
				drift++;
		end
		compare("outputs drifting after done", 48'(drift), 48'd0);
		compare("done pulses", 48'(done_cnt), 48'd1);
		compare("stop seen", 48'(stop_seen), 48'd1);
		compare("dev write byte", 48'(dev_w_seen), 48'({`EEPROM_DEV_PREFIX, 3'd0, 1'b0}));
		if (clean) begin
			compare("word address", 48'(word_seen), 48'(`MAC_WORD_ADDR));
			compare("dev read byte", 48'(dev_r_seen), 48'({`EEPROM_DEV_PREFIX, 3'd0, 1'b1}));
			compare("starts", 48'(start_cnt), 48'd2);
			compare("bytes read", 48'(rd_cnt), 48'(`MAC_BYTES));
			compare("nacked byte", 48'(nack_at), 48'(`MAC_BYTES));
		end else begin
			compare("starts", 48'(start_cnt), 48'd1);
			compare("bytes read", 48'(rd_cnt), 48'd0);
		end
		extra = $urandom % 21;                           // idle gap
		repeat (extra) @(negedge clk);
	endtask

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		model_mac   = '0;
		model_code  = 0;
		errors      = 0;
		checks      = 0;
		cycles      = 0;
		cycle_limit = 1000000;
		void'($urandom(30));
		read_vectors();
		cycle_limit = nvec * DONE_WAIT + 2000;
		checks++;
		assert (nvec > 0) else begin
			errors++;
			$display("ERROR no test vectors were loaded");
		end
		@(negedge clk);
		for (int i = 0; i < nvec; i++)
			run_vector(i);
		$display("vectors: %0d checks: %0d errors: %0d", nvec, checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* sim/eeprom_model.sv */
`timescale 1ns/1ps
`include "mac_reader_defines.svh"

module eeprom_model #(
	parameter logic [2:0] ADDR_PINS = 3'd0   // a2..a0 straps
) (
	input  logic               rst_n,
	input  logic               scl,
	input  logic               sda,
	input  i2c_pkg::mac_addr_t mac_data,
	input  int                 nack_code,    // 0 none, 1 dev addr, 2 word addr
	output logic               sda_oe,
	output i2c_pkg::i2c_byte_t dev_w_seen,
	output i2c_pkg::i2c_byte_t word_seen,
	output i2c_pkg::i2c_byte_t dev_r_seen,
	output int                 rd_cnt,       // bytes sent to master
	output int                 nack_at,      // byte the master nacked
	output int                 start_cnt,    // start plus restart
	output logic               stop_seen
);

	typedef enum logic [2:0] {M_IDLE, M_ADDR, M_WORD, M_SEND, M_SKIP} mode_t;

	mode_t              mode;
	mode_t              next_mode;
	logic               scl_q;
	logic               sda_q;
	i2c_pkg::i2c_byte_t sr;        // master to slave shifter
	i2c_pkg::i2c_byte_t cur;       // byte going out
	int                 bit_idx;
	logic               in_ack;    // inside ninth bit
	logic               ack_clk;   // ninth rising edge seen
	logic               acked;
	int                 ptr;       // eeprom word pointer

	function automatic i2c_pkg::i2c_byte_t byte_at(input int addr);
		int i;
		i = addr - int'(`MAC_WORD_ADDR);
		if (i < 0 || i >= `MAC_BYTES)
			return 8'hFF;                                  // outside the mac area
		return i2c_pkg::i2c_byte_t'(mac_data >> (8 * (`MAC_BYTES - 1 - i)));
	endfunction

	//////////////////////////////
	// bus event decode
	//////////////////////////////

	always @(posedge scl or negedge scl or posedge sda or negedge sda or negedge rst_n) begin
		if (!rst_n) begin
			mode       = M_IDLE;
			next_mode  = M_IDLE;
			sda_oe     = 1'b0;
			sr         = '0;
			cur        = '0;
			bit_idx    = 0;
			in_ack     = 1'b0;
			ack_clk    = 1'b0;
			acked      = 1'b0;
			ptr        = 0;
			dev_w_seen = '0;
			word_seen  = '0;
			dev_r_seen = '0;
			rd_cnt     = 0;
			nack_at    = 0;
			start_cnt  = 0;
			stop_seen  = 1'b0;
		end else if (scl && scl_q && sda_q && !sda) begin
			mode      = M_ADDR;                          // start or restart
			bit_idx   = 0;
			in_ack    = 1'b0;
			ack_clk   = 1'b0;
			sda_oe    = 1'b0;
			start_cnt = start_cnt + 1;
		end else if (scl && scl_q && !sda_q && sda) begin
			stop_seen = 1'b1;
			mode      = M_IDLE;
			sda_oe    = 1'b0;
		end else if (scl && !scl_q) begin
			if (mode == M_ADDR || mode == M_WORD) begin
				if (!in_ack) begin
					sr      = {sr[6:0], sda};                  // msb first
					bit_idx = bit_idx + 1;
				end else
					ack_clk = 1'b1;
			end else if (mode == M_SEND) begin
				if (!in_ack)
					bit_idx = bit_idx + 1;
				else begin
					ack_clk = 1'b1;
					acked   = !sda;                            // master ack low
					if (!acked)
						nack_at = rd_cnt;
				end
			end
		end else if (!scl && scl_q) begin
			if (mode == M_ADDR || mode == M_WORD) begin
				if (in_ack && ack_clk) begin
					sda_oe  = 1'b0;
					in_ack  = 1'b0;
					ack_clk = 1'b0;
					bit_idx = 0;
					mode    = acked ? next_mode : M_SKIP;
					if (mode == M_SEND) begin
						cur    = byte_at(ptr);
						ptr    = ptr + 1;
						rd_cnt = rd_cnt + 1;
						sda_oe = !cur[7];
					end
				end else if (!in_ack && bit_idx == 8) begin
					if (mode == M_WORD) begin
						word_seen = sr;
						ptr       = int'(sr);
						acked     = (nack_code != 2);
						next_mode = M_SKIP;                    // no writes modeled
					end else if (sr[7:1] == {`EEPROM_DEV_PREFIX, ADDR_PINS}) begin
						if (!sr[0]) begin
							dev_w_seen = sr;
							acked      = (nack_code != 1);
							next_mode  = M_WORD;
						end else begin
							dev_r_seen = sr;
							acked      = 1'b1;
							next_mode  = M_SEND;
						end
					end else
						acked = 1'b0;                          // not our address
					in_ack = 1'b1;
					sda_oe = acked;
				end
			end else if (mode == M_SEND) begin
				if (in_ack && ack_clk) begin
					in_ack  = 1'b0;
					ack_clk = 1'b0;
					bit_idx = 0;
					if (acked) begin
						cur    = byte_at(ptr);
						ptr    = ptr + 1;
						rd_cnt = rd_cnt + 1;
						sda_oe = !cur[7];
					end else begin
						mode   = M_SKIP;                       // wait for stop
						sda_oe = 1'b0;
					end
				end else if (!in_ack && bit_idx == 8) begin
					sda_oe = 1'b0;                             // let master ack
					in_ack = 1'b1;
				end else if (!in_ack) begin
					cur    = {cur[6:0], 1'b0};
					sda_oe = !cur[7];
				end
			end
		end
		scl_q = scl;
		sda_q = sda;
	end

endmodule

/* verilog/mac_reader_top.sv */
`timescale 1ns/1ps

module mac_reader_top #(
	parameter logic [2:0] ADDR_PINS = 3'd0   // eeprom address straps
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               sda_in,
	output logic               scl_oe,
	output logic               sda_oe,
	output logic               ready,
	output logic               done,
	output logic               fail,
	output i2c_pkg::mac_addr_t mac
);

	logic               boot_done;
	logic               open;
	logic               close;
	logic               rdata_valid;
	i2c_pkg::i2c_byte_t rdata;
	logic               burst_done;
	logic               err;
	logic               cmd_valid;
	i2c_pkg::i2c_cmd_t  cmd;
	i2c_pkg::i2c_byte_t tx_data;
	logic               rx_nack;
	logic               busy;
	logic               cmd_done;
	i2c_pkg::i2c_byte_t rx_data;
	logic               ack_err;

	//////////////////////////////
	// control path
	//////////////////////////////

	boot_timer u_boot (
		.clk       (clk),
		.rst_n     (rst_n),
		.boot_done (boot_done)
	);

	mac_reader_fsm u_fsm (
		.clk         (clk),
		.rst_n       (rst_n),
		.boot_done   (boot_done),
		.rdata_valid (rdata_valid),
		.rdata       (rdata),
		.burst_done  (burst_done),
		.err         (err),
		.open        (open),
		.close       (close),
		.ready       (ready),
		.done        (done),
		.fail        (fail),
		.mac         (mac)
	);

	//////////////////////////////
	// bus side
	//////////////////////////////

	eeprom_read_sequencer #(
		.ADDR_PINS (ADDR_PINS)
	) u_seq (
		.clk         (clk),
		.rst_n       (rst_n),
		.open        (open),
		.close       (close),
		.busy        (busy),
		.cmd_done    (cmd_done),
		.rx_data     (rx_data),
		.ack_err     (ack_err),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.tx_data     (tx_data),
		.rx_nack     (rx_nack),
		.rdata_valid (rdata_valid),
		.rdata       (rdata),
		.burst_done  (burst_done),
		.err         (err)
	);

	i2c_bit_engine u_bit (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.tx_data   (tx_data),
		.rx_nack   (rx_nack),
		.sda_in    (sda_in),
		.busy      (busy),
		.cmd_done  (cmd_done),
		.rx_data   (rx_data),
		.ack_err   (ack_err),
		.scl_oe    (scl_oe),
		.sda_oe    (sda_oe)
	);

endmodule

/* verilog/mac_reader_fsm.sv */
`timescale 1ns/1ps

module mac_reader_fsm (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               boot_done,
	input  logic               rdata_valid,
	input  i2c_pkg::i2c_byte_t rdata,
	input  logic               burst_done,
	input  logic               err,
	output logic               open,
	output logic               close,
	output logic               ready,
	output logic               done,
	output logic               fail,
	output i2c_pkg::mac_addr_t mac
);

	typedef enum logic [1:0] {ST_BOOT_WAIT, ST_READ, ST_DONE, ST_HOLD} state_t;

	state_t state;
	logic   fail_q;   // sticky error

	assign done  = (state == ST_DONE);    // one cycle only
	assign close = (state == ST_DONE);
	assign fail  = fail_q | err;          // up ahead of done

	//////////////////////////////
	// main state machine
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state  <= ST_BOOT_WAIT;
			open   <= 1'b0;
			ready  <= 1'b0;
			fail_q <= 1'b0;
			mac    <= '0;
		end else begin
			open <= 1'b0;
			if (err)
				fail_q <= 1'b1;
			case (state)
				ST_BOOT_WAIT: if (boot_done) begin
					open  <= 1'b1;
					state <= ST_READ;
				end
				ST_READ: begin
					if (rdata_valid)
						mac <= {mac[39:0], rdata};     // first byte ends up msb
					if (burst_done || err) begin
						ready <= 1'b1;
						state <= ST_DONE;
					end
				end
				ST_DONE: state <= ST_HOLD;
				default: ;                             // hold until reset
			endcase
		end
	end

	// done with ready up and the sequencer gone quiet
	a_done_ready: assert property (@(posedge clk) disable iff (!rst_n)
		done |-> ready && !(rdata_valid || burst_done || err));

endmodule

/* verilog/eeprom_read_sequencer.sv */
`timescale 1ns/1ps
`include "mac_reader_defines.svh"

module eeprom_read_sequencer #(
	parameter logic [2:0] ADDR_PINS = 3'd0   // eeprom a2..a0 strapping
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               open,
	input  logic               close,
	input  logic               busy,
	input  logic               cmd_done,
	input  i2c_pkg::i2c_byte_t rx_data,
	input  logic               ack_err,
	output logic               cmd_valid,
	output i2c_pkg::i2c_cmd_t  cmd,
	output i2c_pkg::i2c_byte_t tx_data,
	output logic               rx_nack,
	output logic               rdata_valid,
	output i2c_pkg::i2c_byte_t rdata,
	output logic               burst_done,
	output logic               err
);

	typedef enum logic [3:0] {
		S_IDLE, S_START, S_DEV_W, S_WORD, S_RESTART, S_DEV_R, S_READ, S_STOP, S_DONE
	} state_t;

	localparam int BW = $clog2(`MAC_BYTES + 1);
	localparam logic [BW-1:0] LAST = BW'(`MAC_BYTES - 1);
	localparam i2c_pkg::i2c_byte_t DEV_W = {`EEPROM_DEV_PREFIX, ADDR_PINS, 1'b0};
	localparam i2c_pkg::i2c_byte_t DEV_R = {`EEPROM_DEV_PREFIX, ADDR_PINS, 1'b1};

	state_t        state;
	logic [BW-1:0] byte_cnt;   // index of read in flight
	logic          nacked;     // some tx was not acked

	//////////////////////////////
	// random read walk
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= S_IDLE;
			cmd_valid   <= 1'b0;
			cmd         <= i2c_pkg::CMD_START;
			tx_data     <= '0;
			rx_nack     <= 1'b0;
			byte_cnt    <= '0;
			nacked      <= 1'b0;
			rdata_valid <= 1'b0;
			burst_done  <= 1'b0;
			err         <= 1'b0;
		end else begin
			cmd_valid   <= 1'b0;
			rdata_valid <= 1'b0;
			burst_done  <= 1'b0;
			err         <= 1'b0;
			case (state)
				S_IDLE: if (open && !busy) begin
					cmd_valid <= 1'b1;
					cmd       <= i2c_pkg::CMD_START;
					nacked    <= 1'b0;
					state     <= S_START;
				end
				S_START: if (cmd_done) begin
					cmd_valid <= 1'b1;
					cmd       <= i2c_pkg::CMD_TX;
					tx_data   <= DEV_W;                   // dummy write sets pointer
					state     <= S_DEV_W;
				end
				S_DEV_W: if (cmd_done) begin
					cmd_valid <= 1'b1;
					cmd       <= i2c_pkg::CMD_TX;
					tx_data   <= `MAC_WORD_ADDR;
					state     <= S_WORD;
				end
				S_WORD: if (cmd_done) begin
					cmd_valid <= 1'b1;
					cmd       <= i2c_pkg::CMD_RESTART;
					state     <= S_RESTART;
				end
				S_RESTART: if (cmd_done) begin
					cmd_valid <= 1'b1;
					cmd       <= i2c_pkg::CMD_TX;
					tx_data   <= DEV_R;
					state     <= S_DEV_R;
				end
				S_DEV_R: if (cmd_done) begin
					cmd_valid <= 1'b1;
					cmd       <= i2c_pkg::CMD_RX;
					rx_nack   <= (LAST == '0);
					byte_cnt  <= '0;
					state     <= S_READ;
				end
				S_READ: if (cmd_done) begin
					rdata_valid <= 1'b1;
					cmd_valid   <= 1'b1;
					if (byte_cnt == LAST) begin
						cmd   <= i2c_pkg::CMD_STOP;
						state <= S_STOP;
					end else begin
						cmd      <= i2c_pkg::CMD_RX;
						rx_nack  <= (byte_cnt + 1'b1 == LAST);   // nack ends the burst
						byte_cnt <= byte_cnt + 1'b1;
					end
				end
				S_STOP: if (cmd_done) begin
					burst_done <= !nacked;
					err        <= nacked;
					state      <= S_DONE;
				end
				S_DONE: if (close)
					state <= S_IDLE;
				default: state <= S_IDLE;
			endcase

			// unacked tx bails out through stop
			if (cmd_done && ack_err &&
				(state == S_DEV_W || state == S_WORD || state == S_DEV_R)) begin
				cmd    <= i2c_pkg::CMD_STOP;
				nacked <= 1'b1;
				state  <= S_STOP;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_READ && cmd_done)
			rdata <= rx_data;                             // hold for the fsm shift
	end

	// one completion flag, bit engine already idle after the stop
	a_one_outcome: assert property (@(posedge clk) disable iff (!rst_n)
		(burst_done || err) |-> !(burst_done && err) && !busy);

endmodule

/* verilog/boot_timer.sv */
`timescale 1ns/1ps
`include "mac_reader_defines.svh"

module boot_timer (
	input  logic clk,
	input  logic rst_n,
	output logic boot_done
);

	localparam int CW = $clog2(`MAC_BOOT_CYCLES + 1);

	logic [CW-1:0] cnt;   // cycles since reset release

	//////////////////////////////
	// saturating delay
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt       <= '0;
			boot_done <= 1'b0;
		end else begin
			boot_done <= (cnt == CW'(`MAC_BOOT_CYCLES - 1));   // single pulse
			if (cnt != CW'(`MAC_BOOT_CYCLES))
				cnt <= cnt + 1'b1;                           // stick at the limit
		end
	end

endmodule

/* verilog/i2c_bit_engine.sv */
`timescale 1ns/1ps
`include "mac_reader_defines.svh"

module i2c_bit_engine (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               cmd_valid,
	input  i2c_pkg::i2c_cmd_t  cmd,
	input  i2c_pkg::i2c_byte_t tx_data,
	input  logic               rx_nack,
	input  logic               sda_in,
	output logic               busy,
	output logic               cmd_done,
	output i2c_pkg::i2c_byte_t rx_data,
	output logic               ack_err,
	output logic               scl_oe,
	output logic               sda_oe
);

	typedef enum logic [2:0] {ST_IDLE, ST_START, ST_STOP, ST_DATA, ST_ACK} state_t;

	localparam int QW = $clog2(`I2C_QUARTER_CYCLES);

	state_t             state;
	logic [QW-1:0]      qcnt;      // clk count within quarter
	logic [1:0]         phase;     // quarter within bit
	logic [2:0]         bit_cnt;   // data bit index
	logic               is_rx;
	logic               nack_q;    // latched rx_nack
	i2c_pkg::i2c_byte_t shreg;     // shared tx/rx shifter
	logic               q_end;
	logic               bit_end;
	logic               mid;
	logic               scl_nx;
	logic               sda_nx;

	assign q_end    = (qcnt == QW'(`I2C_QUARTER_CYCLES - 1));
	assign bit_end  = q_end && (phase == 2'd3);
	assign mid      = q_end && (phase == 2'd1);           // middle of scl high
	assign cmd_done = bit_end && (state == ST_START || state == ST_STOP || state == ST_ACK);
	assign busy     = (state != ST_IDLE) && !cmd_done;   // drops with cmd_done
	assign rx_data  = shreg;

	//////////////////////////////
	// sequencing
	//////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			qcnt    <= '0;
			phase   <= 2'd0;
			bit_cnt <= 3'd0;
			is_rx   <= 1'b0;
			nack_q  <= 1'b0;
			ack_err <= 1'b0;
		end else if (state == ST_IDLE) begin
			qcnt    <= '0;
			phase   <= 2'd0;
			bit_cnt <= 3'd0;
			if (cmd_valid) begin
				is_rx   <= (cmd == i2c_pkg::CMD_RX);
				nack_q  <= rx_nack;
				ack_err <= 1'b0;                          // fresh status per command
				case (cmd)
					i2c_pkg::CMD_START,
					i2c_pkg::CMD_RESTART: state <= ST_START;
					i2c_pkg::CMD_STOP:    state <= ST_STOP;
					default:              state <= ST_DATA;
				endcase
			end
		end else begin
			qcnt <= q_end ? '0 : qcnt + 1'b1;
			if (q_end)
				phase <= phase + 2'd1;                    // wraps at bit end
			if (mid && state == ST_ACK && !is_rx)
				ack_err <= sda_in;                        // high = no ack from slave
			if (bit_end) begin
				bit_cnt <= bit_cnt + 3'd1;
				if (state == ST_DATA && bit_cnt == 3'd7)
					state <= ST_ACK;
				else if (state != ST_DATA)
					state <= ST_IDLE;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == ST_IDLE && cmd_valid)
			shreg <= tx_data;
		else if (state == ST_DATA && is_rx && mid)
			shreg <= {shreg[6:0], sda_in};                // msb first in
		else if (state == ST_DATA && !is_rx && bit_end)
			shreg <= {shreg[6:0], 1'b0};                  // next bit to msb
	end

	//////////////////////////////
	// pin drive
	//////////////////////////////

	always_comb begin
		scl_nx = scl_oe;                                   // idle gap holds the bus
		sda_nx = sda_oe;
		case (state)
			ST_START: begin
				scl_nx = (phase == 2'd0) || (phase == 2'd3);
				sda_nx = phase[1];                         // sda falls while scl high
			end
			ST_STOP: begin
				scl_nx = (phase == 2'd0);
				sda_nx = !phase[1];                        // sda rises while scl high
			end
			ST_DATA: begin
				scl_nx = (phase == 2'd0) || (phase == 2'd3);
				sda_nx = !is_rx && !shreg[7];
			end
			ST_ACK: begin
				scl_nx = (phase == 2'd0) || (phase == 2'd3);
				sda_nx = is_rx && !nack_q;                 // master ack on reads
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scl_oe <= 1'b0;
			sda_oe <= 1'b0;
		end else begin
			scl_oe <= scl_nx;
			sda_oe <= sda_nx;
		end
	end

	// sequencer must wait out the running command
	a_no_cmd_when_busy: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid |-> !busy);

endmodule

/* verilog/i2c_pkg.sv */
package i2c_pkg;

	//////////////////////////////
	// data types
	//////////////////////////////

	typedef logic [7:0]  i2c_byte_t;   // one bus byte
	typedef logic [47:0] mac_addr_t;   // assembled eui-48

	//////////////////////////////
	// bit engine commands
	//////////////////////////////

	typedef enum logic [2:0] {
		CMD_START   = 3'd0,  // start from idle bus
		CMD_RESTART = 3'd1,  // repeated start mid transaction
		CMD_STOP    = 3'd2,  // stop and release bus
		CMD_TX      = 3'd3,  // write byte and read ack
		CMD_RX      = 3'd4   // read byte and send ack or nack
	} i2c_cmd_t;

endpackage

/* verilog/mac_reader_defines.svh */
`ifndef MAC_READER_DEFINES_SVH
`define MAC_READER_DEFINES_SVH

//////////////////////////////
// power-up and bus timing
//////////////////////////////

`define MAC_BOOT_CYCLES     32      // eeprom power-up hold off
`define I2C_QUARTER_CYCLES  4       // clk cycles per quarter scl period

//////////////////////////////
// eeprom layout
//////////////////////////////

`define MAC_WORD_ADDR       8'h9A   // eui-48 location in the mac402
`define MAC_BYTES           6       // bytes per mac read
`define EEPROM_DEV_PREFIX   4'b1011 // upper device address nibble

`endif
